//--- logic/fpu_format_pkg.sv
`default_nettype none

package fpu_format_pkg;

  // ieee single as it sits in memory
  typedef struct packed {
    logic       sign;
    logic [7:0] exp;
    logic [22:0] frac;
  } ieee_word_t;

  // recoded form with one extra exponent bit
  typedef struct packed {
    logic       sign;
    logic [8:0] exp;  // top 3 bits code zero/inf/nan
    logic [22:0] frac;
  } recoded_t;

  typedef logic [4:0] reg_index_t;

  localparam int num_regs = 32;

  localparam logic [7:0] exp_bias_rec = 8'h80;  // offset added when recoding

  // one regfile write port
  typedef struct packed {
    logic       en;
    reg_index_t idx;
    recoded_t   data;
  } reg_write_t;

endpackage

`default_nettype wire

//--- logic/fpu_isa_pkg.sv
`default_nettype none

package fpu_isa_pkg;

  localparam logic [6:0] op_fp       = 7'b1010011;
  localparam logic [6:0] op_store_fp = 7'b0100111;

  localparam logic [4:0] funct5_sgnj = 5'b00100;
  localparam logic [4:0] funct5_mv_x = 5'b11100;  // fmv.x.w
  localparam logic [4:0] funct5_mv_f = 5'b11110;  // fmv.w.x

  localparam logic [2:0] rm_dynamic   = 3'h7;
  localparam logic [2:0] rm_max_legal = 3'h4;

  typedef struct packed {
    logic [6:0]                 funct7;
    fpu_format_pkg::reg_index_t rs2;
    fpu_format_pkg::reg_index_t rs1;
    logic [2:0]                 rm;
    fpu_format_pkg::reg_index_t rd;
    logic [6:0]                 opcode;
  } fp_r_t;

  typedef struct packed {
    logic [6:0]                 imm_hi;
    fpu_format_pkg::reg_index_t rs2;
    fpu_format_pkg::reg_index_t rs1;
    logic [2:0]                 width;
    logic [4:0]                 imm_lo;
    logic [6:0]                 opcode;
  } fp_s_t;

  // one word seen as r-type or store
  typedef union packed {
    fp_r_t r;
    fp_s_t s;
  } fp_inst_t;

  typedef struct packed {
    logic ren1;
    logic ren2;
    logic swap12;    // rs2 onto read port 0
    logic fastpipe;
    logic fromint;
    logic toint;
    logic store;
  } fpu_ctrl_t;

  typedef enum logic [1:0] {
    sgnj_keep   = 2'd0,
    sgnj_negate = 2'd1,
    sgnj_xor    = 2'd2
  } sgnj_kind_t;

endpackage

`default_nettype wire

//--- logic/fpu_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_decode_stage (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       valid,
  input  fpu_isa_pkg::fp_inst_t      inst,
  input  logic [2:0]                 fcsr_rm,
  input  logic                       killx,
  output logic                       ex_valid,
  output fpu_isa_pkg::fpu_ctrl_t     ex_ctrl,
  output fpu_isa_pkg::fp_inst_t      ex_inst,
  output fpu_format_pkg::reg_index_t ra0,
  output fpu_format_pkg::reg_index_t ra1,
  output logic                       illegal_rm
);
  import fpu_isa_pkg::*;

  fpu_ctrl_t  dec_ctrl;
  logic [4:0] funct5;
  logic       fmt_single;

  assign funct5     = inst.r.funct7[6:2];
  assign fmt_single = (inst.r.funct7[1:0] == 2'b00);

  always_comb begin
    dec_ctrl = '0;  // unknown ops pass as bubbles
    if (inst.r.opcode == op_fp && fmt_single) begin
      case (funct5)
        funct5_sgnj: begin
          dec_ctrl.ren1     = 1'b1;
          dec_ctrl.ren2     = 1'b1;
          dec_ctrl.fastpipe = 1'b1;
        end
        funct5_mv_x: begin
          dec_ctrl.ren1  = 1'b1;
          dec_ctrl.toint = (inst.r.rm == 3'b000);  // fclass shares funct5
        end
        funct5_mv_f: dec_ctrl.fromint = (inst.r.rm == 3'b000);
        default: ;
      endcase
    end else if (inst.s.opcode == op_store_fp && inst.s.width == 3'b010) begin
      dec_ctrl.ren2   = 1'b1;
      dec_ctrl.swap12 = 1'b1;
      dec_ctrl.store  = 1'b1;
    end
  end

  assign illegal_rm = (inst.r.rm == 3'h5) || (inst.r.rm == 3'h6) ||
                      (inst.r.rm == rm_dynamic && fcsr_rm > rm_max_legal);

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
      ex_ctrl  <= '0;
      ra0      <= '0;
      ra1      <= '0;
    end else begin
      ex_valid <= valid && !killx;  // a kill flushes the younger issue too
      if (valid) begin
        ex_ctrl <= dec_ctrl;
        if (dec_ctrl.ren2 && dec_ctrl.swap12)
          ra0 <= inst.s.rs2;
        else if (dec_ctrl.ren1 && !dec_ctrl.swap12)
          ra0 <= inst.r.rs1;
        if (dec_ctrl.ren2 && !dec_ctrl.swap12)
          ra1 <= inst.r.rs2;
        else if (dec_ctrl.ren1 && dec_ctrl.swap12)
          ra1 <= inst.r.rs1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (valid)
      ex_inst <= inst;
  end

  a_ctrl_one_direction: assert property (@(posedge clock) disable iff (reset)
    ex_valid |-> !(ex_ctrl.fromint && ex_ctrl.toint))
    else $error("fromint and toint both set in execute");

endmodule

`default_nettype wire

//--- logic/fpu_load_recode.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_load_recode (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       dmem_resp_val,
  input  fpu_format_pkg::reg_index_t dmem_resp_tag,
  input  fpu_format_pkg::ieee_word_t dmem_resp_data,
  output fpu_format_pkg::reg_write_t load_write
);
  import fpu_format_pkg::*;

  logic       load_val;
  reg_index_t load_tag;
  ieee_word_t load_data;

  logic        exp_zero;
  logic        frac_zero;
  logic [4:0]  lz;
  logic [22:0] norm_frac;
  logic [8:0]  exp_adj;
  logic        is_nan;
  recoded_t    rec;

  always_ff @(posedge clock) begin
    if (reset)
      load_val <= 1'b0;
    else
      load_val <= dmem_resp_val;
  end

  always_ff @(posedge clock) begin
    if (dmem_resp_val) begin
      load_tag  <= dmem_resp_tag;
      load_data <= dmem_resp_data;
    end
  end

  // leading zeros counted from the highest set bit
  always_comb begin
    lz = 5'd22;
    for (int i = 0; i < 23; i++) begin
      if (load_data.frac[i])
        lz = 5'(22 - i);
    end
  end

  assign exp_zero  = (load_data.exp == 8'h00);
  assign frac_zero = (load_data.frac == 23'h0);
  assign norm_frac = load_data.frac << (lz + 5'd1);  // drop the hidden one

  assign exp_adj = (exp_zero ? ({4'b0, lz} ^ 9'h1ff) : {1'b0, load_data.exp}) +
                   {1'b0, exp_bias_rec | (exp_zero ? 8'h02 : 8'h01)};

  assign is_nan = (exp_adj[8:7] == 2'b11) && !frac_zero;

  always_comb begin
    rec.sign = load_data.sign;
    rec.exp  = {((exp_zero && frac_zero) ? 3'b000 : exp_adj[8:6]) | {2'b00, is_nan},
                exp_adj[5:0]};
    rec.frac = exp_zero ? norm_frac : load_data.frac;
  end

  assign load_write = '{en: load_val, idx: load_tag, data: rec};

endmodule

`default_nettype wire

//--- logic/fpu_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_regfile (
  input  logic                       clock,
  input  logic                       reset,
  input  fpu_format_pkg::reg_index_t ra0,
  input  fpu_format_pkg::reg_index_t ra1,
  output fpu_format_pkg::recoded_t   rs0,
  output fpu_format_pkg::recoded_t   rs1,
  input  fpu_format_pkg::reg_write_t load_write,
  input  fpu_format_pkg::reg_write_t pipe_write
);
  import fpu_format_pkg::*;

  recoded_t regs [num_regs];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++)
        regs[i] <= '0;
    end else begin
      if (load_write.en)
        regs[load_write.idx] <= load_write.data;
      if (pipe_write.en)
        regs[pipe_write.idx] <= pipe_write.data;  // pipe wins on same index
    end
  end

  assign rs0 = regs[ra0];
  assign rs1 = regs[ra1];

endmodule

`default_nettype wire

//--- logic/fpu_exec_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_exec_pipe (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       ex_valid,
  input  fpu_isa_pkg::fpu_ctrl_t     ex_ctrl,
  input  fpu_isa_pkg::fp_inst_t      ex_inst,
  input  fpu_format_pkg::recoded_t   rs0,
  input  fpu_format_pkg::recoded_t   rs1,
  input  logic [31:0]                fromint_data,
  input  logic                       killx,
  input  logic                       killm,
  output fpu_format_pkg::reg_write_t pipe_write,
  output logic                       busy
);
  import fpu_format_pkg::*;
  import fpu_isa_pkg::*;

  sgnj_kind_t sgnj_kind;
  recoded_t   sgnj_result;
  recoded_t   ex_result;
  logic       ex_wen;

  logic       mem_valid;
  logic       mem_wen;
  reg_index_t mem_rd;
  recoded_t   mem_data;
  logic       wb_valid;
  logic       wb_wen;
  reg_index_t wb_rd;
  recoded_t   wb_data;

  function automatic recoded_t recode_int(input logic [31:0] word);
    ieee_word_t w;
    logic [4:0] lz;
    logic       found;
    logic       sub;
    logic [8:0] e;
    recoded_t   r;
    w     = word;
    sub   = (w.exp == 8'h00);
    lz    = 5'd22;
    found = 1'b0;
    for (int i = 22; i >= 0; i--) begin
      if (!found && w.frac[i]) begin
        lz    = 5'(22 - i);
        found = 1'b1;
      end
    end
    e = sub ? (9'h1ff - {4'b0, lz}) : {1'b0, w.exp};
    e = e + {1'b0, exp_bias_rec} + (sub ? 9'd2 : 9'd1);
    r.sign = w.sign;
    r.frac = sub ? (w.frac << (lz + 5'd1)) : w.frac;
    if (sub && w.frac == 23'h0)
      r.exp = {3'b000, e[5:0]};
    else
      r.exp = {e[8:6] | {2'b00, (e[8:7] == 2'b11) && (w.frac != 23'h0)}, e[5:0]};
    return r;
  endfunction

  assign sgnj_kind = sgnj_kind_t'(ex_inst.r.rm[1:0]);

  always_comb begin
    sgnj_result = rs0;
    case (sgnj_kind)
      sgnj_keep:   sgnj_result.sign = rs1.sign;
      sgnj_negate: sgnj_result.sign = !rs1.sign;
      sgnj_xor:    sgnj_result.sign = rs0.sign ^ rs1.sign;
      default: ;
    endcase
  end

  assign ex_result = ex_ctrl.fromint ? recode_int(fromint_data) : sgnj_result;
  assign ex_wen    = ex_ctrl.fastpipe | ex_ctrl.fromint;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid <= 1'b0;
      mem_wen   <= 1'b0;
      wb_valid  <= 1'b0;
      wb_wen    <= 1'b0;
    end else begin
      mem_valid <= ex_valid && !killx;
      mem_wen   <= ex_wen;
      wb_valid  <= mem_valid && !killm;
      wb_wen    <= mem_wen;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_valid) begin
      mem_rd   <= ex_inst.r.rd;
      mem_data <= ex_result;
    end
    if (mem_valid) begin
      wb_rd   <= mem_rd;
      wb_data <= mem_data;
    end
  end

  assign pipe_write = '{en: wb_valid && wb_wen, idx: wb_rd, data: wb_data};
  assign busy       = ex_valid | mem_valid | wb_valid;

  a_write_from_live_wb: assert property (@(posedge clock) disable iff (reset)
    pipe_write.en |-> wb_valid && $past(mem_valid && !killm))
    else $error("register write without a surviving writeback");

endmodule

`default_nettype wire

//--- logic/fpu_unrecode_out.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_unrecode_out (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     ex_valid,
  input  fpu_isa_pkg::fpu_ctrl_t   ex_ctrl,
  input  fpu_format_pkg::recoded_t rs0,
  output logic [31:0]              store_data,
  output logic [31:0]              toint_data
);
  import fpu_format_pkg::*;

  logic [8:0]  e;
  logic        is_zero;
  logic        is_special;
  logic        is_sub;
  logic [8:0]  den_shift;
  logic [23:0] sub_sig;
  ieee_word_t  ieee_out;
  ieee_word_t  out_word;

  assign e          = rs0.exp;
  assign is_zero    = (e[8:6] == 3'b000);
  assign is_special = (e[8:7] == 2'b11);
  assign is_sub     = !is_zero && (e < {1'b0, exp_bias_rec} + 9'd2);
  assign den_shift  = {1'b0, exp_bias_rec} + 9'd2 - e;
  assign sub_sig    = {1'b1, rs0.frac} >> den_shift;  // hidden one back in

  always_comb begin
    ieee_out.sign = rs0.sign;
    if (is_zero) begin
      ieee_out.exp  = 8'h00;
      ieee_out.frac = 23'h0;
    end else if (is_special) begin
      ieee_out.exp  = 8'hff;
      ieee_out.frac = e[6] ? rs0.frac : 23'h0;  // nan keeps payload
    end else if (is_sub) begin
      ieee_out.exp  = 8'h00;
      ieee_out.frac = sub_sig[22:0];
    end else begin
      ieee_out.exp  = e[7:0] - (exp_bias_rec + 8'd1);
      ieee_out.frac = rs0.frac;
    end
  end

  always_ff @(posedge clock) begin
    if (reset)
      out_word <= '0;
    else if (ex_valid && (ex_ctrl.toint || ex_ctrl.store))
      out_word <= ieee_out;
  end

  assign store_data = out_word;
  assign toint_data = out_word;

endmodule

`default_nettype wire

//--- logic/fpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       valid,
  input  fpu_isa_pkg::fp_inst_t      inst,
  input  logic [2:0]                 fcsr_rm,
  input  logic [31:0]                fromint_data,
  input  logic                       killx,
  input  logic                       killm,
  input  logic                       dmem_resp_val,
  input  fpu_format_pkg::reg_index_t dmem_resp_tag,
  input  fpu_format_pkg::ieee_word_t dmem_resp_data,
  output logic [31:0]                store_data,
  output logic [31:0]                toint_data,
  output logic                       fcsr_rdy,
  output logic                       illegal_rm
);
  import fpu_format_pkg::*;
  import fpu_isa_pkg::*;

  logic       ex_valid;
  fpu_ctrl_t  ex_ctrl;
  fp_inst_t   ex_inst;
  reg_index_t ra0;
  reg_index_t ra1;
  recoded_t   rs0;
  recoded_t   rs1;
  reg_write_t load_write;
  reg_write_t pipe_write;
  logic       busy;

  fpu_decode_stage u_decode (
    .clock, .reset, .valid, .inst, .fcsr_rm, .killx,
    .ex_valid, .ex_ctrl, .ex_inst, .ra0, .ra1, .illegal_rm
  );

  fpu_load_recode u_load (
    .clock, .reset, .dmem_resp_val, .dmem_resp_tag, .dmem_resp_data, .load_write
  );

  fpu_regfile u_regfile (
    .clock, .reset, .ra0, .ra1, .rs0, .rs1, .load_write, .pipe_write
  );

  fpu_exec_pipe u_exec (
    .clock, .reset, .ex_valid, .ex_ctrl, .ex_inst, .rs0, .rs1, .fromint_data,
    .killx, .killm, .pipe_write, .busy
  );

  fpu_unrecode_out u_unrecode (
    .clock, .reset, .ex_valid, .ex_ctrl, .rs0, .store_data, .toint_data
  );

  assign fcsr_rdy = !busy;

endmodule

`default_nettype wire

//--- test/fpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fpu_tb;
  import fpu_isa_pkg::*;

  logic        clock;
  logic        reset;
  logic        valid;
  logic [31:0] inst;
  logic [2:0]  fcsr_rm;
  logic [31:0] fromint_data;
  logic        killx;
  logic        killm;
  logic        dmem_resp_val;
  logic [4:0]  dmem_resp_tag;
  logic [31:0] dmem_resp_data;
  logic [31:0] store_data;
  logic [31:0] toint_data;
  logic        fcsr_rdy;
  logic        illegal_rm;

  int          checks;
  int          errors;
  int          timeouts;
  int          fd;
  logic [39:0] cmd;  // up to five characters
  logic [4:0]  a;
  logic [4:0]  b;
  logic [4:0]  c;
  logic [31:0] data;
  logic [31:0] want;

  fpu_top u_dut (
    .clock, .reset, .valid, .inst, .fcsr_rm, .fromint_data, .killx, .killm,
    .dmem_resp_val, .dmem_resp_tag, .dmem_resp_data,
    .store_data, .toint_data, .fcsr_rdy, .illegal_rm
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] encode_r(input logic [4:0] f5, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] rm,
                                           input logic [4:0] rd);
    return {f5, 2'b00, rs2, rs1, rm, rd, op_fp};  // single-precision fmt
  endfunction

  task check_word(input string name, input logic [31:0] got, input logic [31:0] exp_val);
    checks++;
    assert (got === exp_val) else begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp_val);
    end
  endtask

  task wait_ready(input int limit);
    int count;
    count = 0;
    @(negedge clock);
    while (!fcsr_rdy && count < limit) begin
      @(negedge clock);
      count++;
    end
    if (!fcsr_rdy) begin
      timeouts++;
      $display("timeout at %0t: fcsr_rdy still low after %0d cycles", $time, limit);
    end
  endtask

  task load_reg(input logic [4:0] rd, input logic [31:0] word);
    @(posedge clock);
    dmem_resp_val  <= 1'b1;
    dmem_resp_tag  <= rd;
    dmem_resp_data <= word;
    @(posedge clock);
    dmem_resp_val <= 1'b0;
    repeat (4) @(posedge clock);  // written one cycle after the response
  endtask

  // issue in cycle 0 and sample each later cycle at its falling edge
  task run_op(input logic [31:0] word, input logic [31:0] fi, input logic kx,
              input logic km, input logic [1:0] sel, input logic [31:0] exp_val);
    @(posedge clock);
    valid        <= 1'b1;
    inst         <= word;
    fromint_data <= fi;
    @(posedge clock);
    valid <= 1'b0;
    killx <= kx;
    @(negedge clock);
    check_word("fcsr_rdy", {31'b0, fcsr_rdy}, 32'h0);
    @(posedge clock);
    killx <= 1'b0;
    killm <= km;
    @(negedge clock);
    if (!kx)
      check_word("fcsr_rdy", {31'b0, fcsr_rdy}, 32'h0);
    if (sel == 2'd1)
      check_word("toint_data", toint_data, exp_val);
    if (sel == 2'd2)
      check_word("store_data", store_data, exp_val);
    @(posedge clock);
    killm <= 1'b0;
    @(negedge clock);
    if (!kx && !km)
      check_word("fcsr_rdy", {31'b0, fcsr_rdy}, 32'h0);
    wait_ready(10);
  endtask

  task check_rm(input logic [2:0] rm, input logic [2:0] frm, input logic exp_bit);
    @(posedge clock);
    inst    <= encode_r(funct5_sgnj, 5'd0, 5'd0, rm, 5'd0);
    fcsr_rm <= frm;
    @(negedge clock);
    check_word("illegal_rm", {31'b0, illegal_rm}, {31'b0, exp_bit});
  endtask

  initial begin
    checks         = 0;
    errors         = 0;
    timeouts       = 0;
    reset          <= 1'b1;
    valid          <= 1'b0;
    inst           <= 32'h0;
    fcsr_rm        <= 3'd0;
    fromint_data   <= 32'h0;
    killx          <= 1'b0;
    killm          <= 1'b0;
    dmem_resp_val  <= 1'b0;
    dmem_resp_tag  <= 5'd0;
    dmem_resp_data <= 32'h0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_word("fcsr_rdy", {31'b0, fcsr_rdy}, 32'h1);
    fd = $fopen("test/fpu_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the pattern file test/fpu_patterns.txt");
    end else begin
      while ($fscanf(fd, "%s %d %d %d %h %h\n", cmd, a, b, c, data, want) == 6) begin
        case (cmd)
          {8'h0, "load"}: load_reg(a, data);
          {8'h0, "sgnj"}: run_op(encode_r(funct5_sgnj, c, b, data[2:0], a), 32'h0,
                                 1'b0, 1'b0, 2'd0, 32'h0);
          {8'h0, "mvwx"}: run_op(encode_r(funct5_mv_f, 5'd0, 5'd0, 3'd0, a), data,
                                 1'b0, 1'b0, 2'd0, 32'h0);
          {8'h0, "mvxw"}: run_op(encode_r(funct5_mv_x, 5'd0, a, 3'd0, 5'd0), 32'h0,
                                 1'b0, 1'b0, 2'd1, want);
          "store": run_op({7'h0, a, b, 3'b010, 5'h0, op_store_fp}, 32'h0,
                          1'b0, 1'b0, 2'd2, want);  // operand from rs2
          "killx": run_op(encode_r(funct5_mv_f, 5'd0, 5'd0, 3'd0, a), data,
                          1'b1, 1'b0, 2'd0, 32'h0);
          "killm": run_op(encode_r(funct5_mv_f, 5'd0, 5'd0, 3'd0, a), data,
                          1'b0, 1'b1, 2'd0, 32'h0);
          "rmchk": check_rm(a[2:0], b[2:0], want[0]);
          default: begin
            errors++;
            $display("unknown command in the pattern file at %0t", $time);
          end
        endcase
      end
      $fclose(fd);
    end
    wait_ready(20);
    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/fpu_patterns.txt
load 1 0 0 80000000 00000000
load 2 0 0 00012345 00000000
load 3 0 0 c0490fdb 00000000
load 4 0 0 7f800000 00000000
load 5 0 0 7fc00001 00000000
mvxw 1 0 0 00000000 80000000
mvxw 2 0 0 00000000 00012345
mvxw 3 0 0 00000000 c0490fdb
mvxw 4 0 0 00000000 7f800000
mvxw 5 0 0 00000000 7fc00001
sgnj 6 3 4 00000000 00000000
mvxw 6 0 0 00000000 40490fdb
sgnj 7 3 4 00000001 00000000
store 7 1 0 00000000 c0490fdb
sgnj 8 3 1 00000002 00000000
mvxw 8 0 0 00000000 40490fdb
mvwx 9 0 0 00000001 00000000
mvxw 9 0 0 00000000 00000001
killx 3 0 0 3f800000 00000000
mvxw 3 0 0 00000000 c0490fdb
killm 2 0 0 3f800000 00000000
mvxw 2 0 0 00000000 00012345
rmchk 5 0 0 00000000 00000001
rmchk 6 0 0 00000000 00000001
rmchk 7 4 0 00000000 00000000
rmchk 7 5 0 00000000 00000001
rmchk 2 7 0 00000000 00000000

//--- sources.f
logic/fpu_format_pkg.sv
logic/fpu_isa_pkg.sv
logic/fpu_decode_stage.sv
logic/fpu_load_recode.sv
logic/fpu_regfile.sv
logic/fpu_exec_pipe.sv
logic/fpu_unrecode_out.sv
logic/fpu_top.sv
test/fpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module fpu_tb \
  -f sources.f -o fpu_sim &&
  ./obj_dir/fpu_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null ||
  exit 1
